//--- common/huff_pkg.sv
package huff_pkg;

    // widths and sizes
    localparam int SYM_W      = 8;  // char index, lefts count, one byte
    localparam int FIFO_DEPTH = 8;  // bytes held by the output buffer
    localparam int CNT_W      = 4;  // bit counters in serializer and packer

    // one header field is a leading 1 plus a symbol-wide value
    localparam int HDR_LEN = SYM_W + 1;

    // fifo pointer and occupancy widths
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int OCC_W = PTR_W + 1;  // room for the full count

    // counter compare values, sized to the counters
    localparam logic [CNT_W-1:0] HDR_LAST  = CNT_W'(HDR_LEN - 1);  // last bit of a field
    localparam logic [CNT_W-1:0] BYTE_BITS = CNT_W'(SYM_W);        // bits per byte
    localparam logic [CNT_W-1:0] BYTE_LAST = CNT_W'(SYM_W - 1);    // 8th bit of a byte
    localparam logic [OCC_W-1:0] FIFO_FULL = OCC_W'(FIFO_DEPTH);

    // serializer states
    typedef enum logic [1:0] {
        HDR_IDLE,   // waiting for a walk event
        HDR_CHAR,   // leading 1 + char index
        HDR_LEFTS,  // leading 1 + lefts count
        HDR_ZERO    // one backtrack zero
    } hdr_state_e;

    // pulses from the tree walker, sampled while not busy
    typedef struct packed {
        logic             char_found;  // leaf reached
        logic             backtrack;   // walk went up one level
        logic             left;        // found char is a left child
        logic [SYM_W-1:0] char_index;
        logic [SYM_W-1:0] num_lefts;
    } walk_event_t;

    // one serial header bit
    typedef struct packed {
        logic valid;  // bit present this cycle
        logic value;
    } hdr_bit_t;

    // one packed byte toward the buffer
    typedef struct packed {
        logic             valid;  // push strobe
        logic [SYM_W-1:0] data;
    } hdr_byte_t;

endpackage

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    input  huff_pkg::hdr_byte_t        pbyte,     // push strobe and byte
    input  logic                       rd,        // pop strobe
    output logic [huff_pkg::SYM_W-1:0] rd_data,   // head, valid while not empty
    output logic                       empty,
    output logic                       overflow   // sticky, a push was dropped
);

    logic [huff_pkg::SYM_W-1:0] mem [huff_pkg::FIFO_DEPTH];

    logic [huff_pkg::PTR_W-1:0] wr_ptr;  // wraps with the depth
    logic [huff_pkg::PTR_W-1:0] rd_ptr;
    logic [huff_pkg::OCC_W-1:0] occ;     // bytes stored
    logic                       full;
    logic                       do_rd;   // pop accepted
    logic                       do_wr;   // push accepted

    assign empty = (occ == '0);
    assign full  = (occ == huff_pkg::FIFO_FULL);
    assign do_rd = rd && !empty;                      // rd on empty is ignored
    assign do_wr = pbyte.valid && (!full || do_rd);   // a pop frees a slot

    // first-word fall-through head
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            occ      <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;  // none, or push and pop together
            endcase
            if (pbyte.valid && !do_wr) begin
                overflow <= 1'b1;  // byte lost, held until reset
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= pbyte.data;
        end
    end

endmodule

//--- hdl/byte_packer.sv
`timescale 1ns/1ps

module byte_packer (
    input  logic                clk,
    input  logic                rst_n,
    input  huff_pkg::hdr_bit_t  hbit,   // serial header bits
    input  logic                flush,  // pad out the partial byte
    output huff_pkg::hdr_byte_t pbyte   // registered push toward the fifo
);

    logic [huff_pkg::SYM_W-1:0] shreg;     // pending bits, newest in lsb
    logic [huff_pkg::SYM_W-1:0] with_bit;  // pending bits plus the incoming one
    logic [huff_pkg::CNT_W-1:0] cnt;       // bits pending, 0..7
    logic [huff_pkg::CNT_W-1:0] pad_sh;    // left shift that aligns a partial byte

    assign with_bit = {shreg[huff_pkg::SYM_W-2:0], hbit.value};
    assign pad_sh   = huff_pkg::BYTE_BITS - cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            pbyte <= '0;
        end else begin
            pbyte.valid <= 1'b0;  // push is a one-cycle strobe
            if (hbit.valid) begin
                if (cnt == huff_pkg::BYTE_LAST) begin
                    // 8th bit completes the byte, msb was the oldest bit
                    pbyte <= '{valid: 1'b1, data: with_bit};
                    cnt   <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end else if (flush && (cnt != '0)) begin
                // stale upper bits fall off, zeros fill from the right
                pbyte <= '{valid: 1'b1, data: shreg << pad_sh};
                cnt   <= '0;
            end
        end
    end

    // bit shift register
    always_ff @(posedge clk) begin
        if (hbit.valid) begin
            shreg <= with_bit;
        end
    end

endmodule

//--- hdl/huff_header_top.sv
`timescale 1ns/1ps

module huff_header_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  huff_pkg::walk_event_t      evt,       // tree walker pulses
    input  logic                       flush,     // only while busy is low
    input  logic                       rd,        // byte read strobe
    output logic [huff_pkg::SYM_W-1:0] rd_data,
    output logic                       empty,
    output logic                       overflow,
    output logic                       busy       // serializer mid-event
);

    huff_pkg::hdr_bit_t  hbit;   // serializer to packer
    huff_pkg::hdr_byte_t pbyte;  // packer to buffer

    // events become header bits
    header_synth i_header_synth (
        .clk   (clk),
        .rst_n (rst_n),
        .evt   (evt),
        .hbit  (hbit),
        .busy  (busy)
    );

    // bits become bytes, msb first
    byte_packer i_byte_packer (
        .clk   (clk),
        .rst_n (rst_n),
        .hbit  (hbit),
        .flush (flush),
        .pbyte (pbyte)
    );

    // bytes wait here for the reader
    byte_fifo i_byte_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .pbyte    (pbyte),
        .rd       (rd),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow)
    );

endmodule

//--- header_synth/header_synth.sv
`timescale 1ns/1ps

module header_synth (
    input  logic                  clk,
    input  logic                  rst_n,
    input  huff_pkg::walk_event_t evt,   // walker pulses
    output huff_pkg::hdr_bit_t    hbit,  // one header bit per cycle
    output logic                  busy   // events ignored while high
);

    huff_pkg::hdr_state_e state, next_state;

    logic [huff_pkg::HDR_LEN-1:0] shreg, next_shreg;  // field being sent msb first
    logic [huff_pkg::CNT_W-1:0]   cnt, next_cnt;      // bits of the field sent so far
    logic                         left_q, next_left;  // latched left flag
    logic [huff_pkg::SYM_W-1:0]   lefts_q, next_lefts;
    logic                         last_bit;           // final bit of a 9-bit field
    logic                         lefts_due;          // lefts field follows the char

    assign last_bit  = (cnt == huff_pkg::HDR_LAST);
    assign lefts_due = left_q && (lefts_q != '0);  // zero count sends nothing

    // next-state logic
    always_comb begin
        next_state = state;
        next_shreg = shreg;
        next_cnt   = cnt;
        next_left  = left_q;
        next_lefts = lefts_q;

        case (state)
            huff_pkg::HDR_IDLE: begin
                if (evt.char_found) begin  // wins over a coincident backtrack
                    next_state = huff_pkg::HDR_CHAR;
                    next_shreg = {1'b1, evt.char_index};  // leading 1 then index
                    next_cnt   = '0;
                    next_left  = evt.left;
                    next_lefts = evt.num_lefts;
                end else if (evt.backtrack) begin
                    next_state = huff_pkg::HDR_ZERO;
                    next_shreg = '0;  // msb is the backtrack zero
                end
            end

            huff_pkg::HDR_CHAR: begin
                next_shreg = {shreg[huff_pkg::HDR_LEN-2:0], 1'b0};  // shift out msb
                next_cnt   = cnt + 1'b1;
                if (last_bit) begin
                    next_cnt = '0;
                    if (lefts_due) begin
                        // lefts field starts right after the char bits
                        next_state = huff_pkg::HDR_LEFTS;
                        next_shreg = {1'b1, lefts_q};
                    end else begin
                        next_state = huff_pkg::HDR_IDLE;
                    end
                end
            end

            huff_pkg::HDR_LEFTS: begin
                next_shreg = {shreg[huff_pkg::HDR_LEN-2:0], 1'b0};
                next_cnt   = cnt + 1'b1;
                if (last_bit) begin
                    next_cnt   = '0;
                    next_state = huff_pkg::HDR_IDLE;  // event done
                end
            end

            huff_pkg::HDR_ZERO: begin
                next_state = huff_pkg::HDR_IDLE;  // single bit only
            end

            default: begin
                next_state = huff_pkg::HDR_IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= huff_pkg::HDR_IDLE;
            cnt   <= '0;
        end else begin
            state <= next_state;
            cnt   <= next_cnt;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        shreg   <= next_shreg;
        left_q  <= next_left;
        lefts_q <= next_lefts;
    end

    // a bit goes out in every non-idle cycle
    assign busy = (state != huff_pkg::HDR_IDLE);
    assign hbit = '{valid: busy,
                    value: busy & shreg[huff_pkg::HDR_LEN-1]};  // keep value quiet when idle

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the huffman header testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps \
        --top-module tb_huff_header -Mdir obj_dir -f src.f; then
    echo "verilator build failed"
    exit 1
fi

if [ ! -x ./obj_dir/Vtb_huff_header ]; then
    echo "simulation binary missing"
    exit 1
fi

out=$(./obj_dir/Vtb_huff_header)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1

//--- src.f
common/huff_pkg.sv
header_synth/header_synth.sv
hdl/byte_packer.sv
hdl/byte_fifo.sv
hdl/huff_header_top.sv
testbench/tb_clock.sv
testbench/tb_huff_header.sv

//--- testbench/header_input.txt
# commands: char <index hex> <left 0|1> <lefts hex> | back | busy_back | flush | rd_empty | drain
#           expect <byte hex> or expect ov ; expected bytes are checked at the next drain

# single character, then a read on the empty buffer
char a5 0 00
flush
expect d2
expect 80
drain
rd_empty

# eight backtracks fill a byte without a flush
back
back
back
back
back
back
back
back
expect 00
drain

# three backtracks padded by a flush
back
back
back
flush
expect 00
drain

# left character with a lefts field
char 3c 1 05
flush
expect 9e
expect 41
expect 40
drain

# left character with zero lefts sends only the char bits
char 7e 1 00
flush
expect bf
expect 00
drain

# backtrack during busy must not add a bit
char 81 0 00
busy_back
char ff 0 00
flush
expect c0
expect ff
expect c0
drain

# mixed walk
back
back
char 41 1 02
back
char 42 0 00
back
back
back
char 43 1 00
flush
expect 28
expect 30
expect 25
expect 08
expect 50
expect c0
drain

# nine bytes without a read, the last one is dropped
char 11 0 00
char 22 0 00
char 33 0 00
char 44 0 00
char 55 0 00
char 66 0 00
char 77 0 00
char 88 0 00
flush
expect 88
expect c8
expect a6
expect 74
expect 4a
expect ad
expect 9a
expect ef
expect ov
drain

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset held low for the first 3 rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- testbench/tb_huff_header.sv
`timescale 1ns/1ps

module tb_huff_header;

    logic                       clk;
    logic                       rst_n;
    huff_pkg::walk_event_t      evt;
    logic                       flush;
    logic                       rd;
    logic [huff_pkg::SYM_W-1:0] rd_data;
    logic                       empty;
    logic                       overflow;
    logic                       busy;

    string      lines[$];       // command lines of the data file
    logic [7:0] model_q[$];     // bytes the buffer should hold
    logic [7:0] file_q[$];      // bytes listed in the data file
    logic [7:0] pend;           // model bits not yet a byte with the newest in lsb
    int         pend_cnt = 0;
    logic       model_ovf = 1'b0;
    logic       file_ovf = 1'b0;
    logic [15:0] lfsr = 16'd88;  // read gap source
    int         checks = 0;
    int         cycles = 0;
    int         limit = 0;       // 0 until the data file is loaded

    tb_clock i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    huff_header_top i_huff_header_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .evt      (evt),
        .flush    (flush),
        .rd       (rd),
        .rd_data  (rd_data),
        .empty    (empty),
        .overflow (overflow),
        .busy     (busy)
    );

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: no progress after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            $display("** Error at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic reject_line(input string line);
        $display("malformed line in the data file: %s", line);
        $display("CHECKS FAILED");
        $fatal(1, "bad stimulus");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic pick_gap(output int gap);
        gap = 0;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_step(lfsr);  // one step per bit taken
            gap  = gap * 2 + int'(lfsr[0]);
        end
    endtask

    // reference bit stream built from the header rules
    task automatic model_byte(input logic [7:0] b);
        if (model_q.size() < huff_pkg::FIFO_DEPTH) begin
            model_q.push_back(b);
        end else begin
            model_ovf = 1'b1;  // buffer full so the byte is lost
        end
    endtask

    task automatic model_bit(input logic b);
        pend = {pend[6:0], b};
        pend_cnt++;
        if (pend_cnt == 8) begin
            model_byte(pend);
            pend_cnt = 0;
        end
    endtask

    task automatic model_flush;
        if (pend_cnt != 0) begin
            model_byte(pend << (8 - pend_cnt));  // left align and zero pad
            pend_cnt = 0;
        end
    endtask

    task automatic model_char(input logic [7:0] idx, input logic left,
                              input logic [7:0] lefts);
        model_bit(1'b1);
        for (int i = 7; i >= 0; i--) begin
            model_bit(idx[i]);
        end
        if (left && lefts != 8'd0) begin
            model_bit(1'b1);  // lefts field
            for (int i = 7; i >= 0; i--) begin
                model_bit(lefts[i]);
            end
        end
    endtask

    task automatic wait_idle;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic send_event(input huff_pkg::walk_event_t e);
        wait_idle();
        @(posedge clk);
        evt <= e;
        @(posedge clk);
        evt <= '0;  // one-cycle pulse
    endtask

    task automatic pulse_busy_backtrack;
        huff_pkg::walk_event_t e;
        e           = '0;
        e.backtrack = 1'b1;
        @(negedge clk);
        check(32'(busy), 32'd1, "busy before the ignored backtrack");
        @(posedge clk);
        evt <= e;
        @(posedge clk);
        evt <= '0;
    endtask

    task automatic send_flush;
        wait_idle();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic read_empty;
        @(negedge clk);
        check(32'(empty), 32'd1, "empty before the stray read");
        @(posedge clk);
        rd <= 1'b1;
        @(posedge clk);
        rd <= 1'b0;
        @(negedge clk);
        check(32'(empty), 32'd1, "empty after the stray read");
        check(32'(overflow), 32'(model_ovf), "overflow after the stray read");
    endtask

    task automatic drain_bytes;
        logic [7:0] exp_b;
        logic [7:0] file_b;
        int         gap;
        wait_idle();
        check(32'(file_q.size()), 32'(model_q.size()), "byte count in the data file");
        while (model_q.size() > 0) begin
            exp_b  = model_q.pop_front();
            file_b = file_q.pop_front();
            check(32'(file_b), 32'(exp_b), "data file byte against the bit rules");
            pick_gap(gap);
            repeat (gap) @(posedge clk);
            @(negedge clk);
            while (empty) begin  // byte may still be in flight
                @(negedge clk);
            end
            check(32'(rd_data), 32'(exp_b), "rd_data");
            @(posedge clk);
            rd <= 1'b1;
            @(posedge clk);
            rd <= 1'b0;
        end
        @(negedge clk);
        check(32'(empty), 32'd1, "empty after the drain");
        check(32'(overflow), 32'(model_ovf), "overflow flag");
        check(32'(model_ovf), 32'(file_ovf), "overflow in the data file");
    endtask

    task automatic load_commands;
        int    fd;
        string line;
        string cmd;
        fd = $fopen("testbench/header_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/header_input.txt");
            $display("CHECKS FAILED");
            $fatal(1, "no stimulus");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cmd  = "";
                if ($fgets(line, fd) > 0) begin
                    // skip blank and # lines
                    if ($sscanf(line, "%s", cmd) == 1 && cmd.getc(0) != "#") begin
                        lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_command(input string line);
        string                 cmd;
        string                 arg;
        logic [7:0]            idx;
        logic [7:0]            lefts;
        logic [7:0]            val;
        int                    left_v;
        huff_pkg::walk_event_t e;
        void'($sscanf(line, "%s", cmd));
        e = '0;
        if (cmd == "char") begin
            if ($sscanf(line, "%s %h %d %h", cmd, idx, left_v, lefts) != 4) begin
                reject_line(line);
            end else begin
                e.char_found = 1'b1;
                e.left       = (left_v != 0);
                e.char_index = idx;
                // count is ignored for a right child and driven nonzero
                e.num_lefts  = e.left ? lefts : (lefts | 8'h80);
                model_char(idx, e.left, e.num_lefts);
                send_event(e);
            end
        end else if (cmd == "back") begin
            e.backtrack = 1'b1;
            model_bit(1'b0);
            send_event(e);
        end else if (cmd == "busy_back") begin
            pulse_busy_backtrack();  // no model bit
        end else if (cmd == "flush") begin
            model_flush();
            send_flush();
        end else if (cmd == "rd_empty") begin
            read_empty();
        end else if (cmd == "drain") begin
            drain_bytes();
        end else if (cmd == "expect" && $sscanf(line, "%s %s", cmd, arg) == 2) begin
            if (arg == "ov") begin
                file_ovf = 1'b1;
            end else if ($sscanf(arg, "%h", val) == 1) begin
                file_q.push_back(val);
            end else begin
                reject_line(line);
            end
        end else begin
            reject_line(line);
        end
    endtask

    initial begin
        evt   <= '0;
        flush <= 1'b0;
        rd    <= 1'b0;
        load_commands();
        limit = 20 * lines.size() + 200;  // per command line plus slack
        @(posedge rst_n);
        @(negedge clk);
        check(32'(empty), 32'd1, "empty after reset");
        check(32'(busy), 32'd0, "busy after reset");
        check(32'(overflow), 32'd0, "overflow after reset");
        foreach (lines[i]) begin
            run_command(lines[i]);
        end
        check(32'(model_q.size()), 32'd0, "bytes left undrained at the end");
        $display("%0d checks done in %0d cycles", checks, cycles);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
